// ==== gr_pad.f ====
+incdir+source
source/gr_pad_pkg.sv
source/pad_control.sv
source/pad_mux.sv
source/pad_ring.sv
source/gr_pad_top.sv
bench/gr_pad_assert.sv
bench/gr_pad_tb.sv

// ==== Makefile ====
# Verilator flow for the pad block

VERILATOR  ?= verilator
TOP        := gr_pad_tb
FILELIST   := gr_pad.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG) || { echo "Pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/gr_pad_tb.sv ====
/*
  Testbench for gr_pad_top.
  Inputs change on the falling clock edge. Outputs are sampled on the
  next falling edge. Random stimulus comes from a fixed seed. A small
  model keeps both registers and the two-deep pad input pipeline.
  No requests are issued while the reset synchronizer releases.
*/
`include "gr_pad_params.svh"

module gr_pad_tb import gr_pad_pkg::*; ();

  localparam int N_REG  = 200;
  localparam int N_OUT  = 100;
  localparam int N_IN   = 100;
  localparam int N_PULL = 100;
  // Cycle budget of all tests plus a margin
  localparam int TIMEOUT_CYCLES = 20 + 2 * N_REG + N_OUT + N_IN + N_PULL + 100;

  logic      clk;
  logic      rst_n;
  logic      reg_valid;
  logic      reg_write;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      reg_rvalid;
  pad_vec_t  prim_out, prim_oe, prim_in;
  pad_vec_t  alt_out, alt_oe, alt_in;
  pad_vec_t  pad_in, pad_out, pad_oe, pad_pull;

  integer    seed;
  int        cycles;
  int        checks;
  int        errors;
  int        err0;
  reg_addr_t addr;
  reg_data_t r;
  pad_vec_t  mux_m;
  pad_vec_t  pull_m;
  pad_vec_t  meta_m;
  pad_vec_t  sync_m;

  gr_pad_top gr_pad_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .reg_rvalid_o(reg_rvalid),
    .prim_out_i  (prim_out),
    .prim_oe_i   (prim_oe),
    .prim_in_o   (prim_in),
    .alt_out_i   (alt_out),
    .alt_oe_i    (alt_oe),
    .alt_in_o    (alt_in),
    .pad_i       (pad_in),
    .pad_o       (pad_out),
    .pad_oe_o    (pad_oe),
    .pad_pull_o  (pad_pull)
  );

  bind gr_pad_top gr_pad_assert gr_pad_assert_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .reg_valid_i(reg_valid_i),
    .reg_write_i(reg_write_i),
    .rvalid_i   (reg_rvalid_o),
    .pad_oe_i   (pad_oe_o),
    .pad_pull_i (pad_pull_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_vec(input string name, input pad_vec_t exp, input pad_vec_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus and model
  // ----------------------------------------------------------

  function automatic reg_data_t rand_data();
    reg_data_t v;
    v = $random(seed);
    return v;
  endfunction

  function automatic pad_vec_t rand_vec();
    reg_data_t v;
    v = $random(seed);
    return v[`GR_PAD_NUM-1:0];
  endfunction

  // Half the picks hit a real register
  function automatic reg_addr_t pick_addr();
    reg_data_t v;
    v = $random(seed);
    case (v[1:0])
      2'd0:    return `GR_PAD_MUX_OFFSET;
      2'd1:    return `GR_PAD_PULL_OFFSET;
      default: return v[`GR_PAD_REG_AW+1:2];
    endcase
  endfunction

  function automatic reg_data_t model_read(input reg_addr_t a);
    reg_data_t d;
    d = '0;
    if (a == `GR_PAD_MUX_OFFSET) begin
      d[`GR_PAD_NUM-1:0] = mux_m;
    end else if (a == `GR_PAD_PULL_OFFSET) begin
      d[`GR_PAD_NUM-1:0] = pull_m;
    end
    return d;
  endfunction

  task automatic idle_port();
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  // Model takes the write at the coming rising edge
  task automatic write_reg(input reg_addr_t a, input reg_data_t data);
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr  = a;
    reg_wdata = data;
    if (a == `GR_PAD_MUX_OFFSET) begin
      mux_m = data[`GR_PAD_NUM-1:0];
    end else if (a == `GR_PAD_PULL_OFFSET) begin
      pull_m = data[`GR_PAD_NUM-1:0];
    end
  endtask

  task automatic read_check(input reg_addr_t a);
    reg_data_t exp;
    exp = model_read(a);
    reg_valid = 1'b1;
    reg_write = 1'b0;
    reg_addr  = a;
    reg_wdata = rand_data();
    @(negedge clk);
    idle_port();
    check_bit("reg_rvalid_o", 1'b1, reg_rvalid);
    check_data("reg_rdata_o", exp, reg_rdata);
  endtask

  task automatic check_pads();
    pad_vec_t exp_oe;
    exp_oe = (mux_m & alt_oe) | (~mux_m & prim_oe);
    check_vec("pad_o", (mux_m & alt_out) | (~mux_m & prim_out), pad_out);
    check_vec("pad_oe_o", exp_oe, pad_oe);
    check_vec("pad_pull_o", pull_m & ~exp_oe, pad_pull);
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("Test %s finished with %0d errors", name, errors - err_start);
  endtask

  initial begin
    seed      = 32'h97116945;
    clk       = 1'b0;
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    prim_out  = '0;
    alt_out   = '0;
    // Enables high so that gating in reset shows
    prim_oe   = '1;
    alt_oe    = '1;
    pad_in    = '0;
    mux_m     = '0;
    pull_m    = '0;
    meta_m    = '0;
    sync_m    = '0;
    cycles    = 0;
    checks    = 0;
    errors    = 0;

    // ----------------------------------------------------------
    // Reset state
    // ----------------------------------------------------------
    err0 = errors;
    repeat (4) begin
      @(negedge clk);
      check_vec("pad_oe_o", '0, pad_oe);
      check_bit("reg_rvalid_o", 1'b0, reg_rvalid);
    end
    rst_n = 1'b1;
    // Two edges for the synchronizer and one spare
    repeat (3) begin
      @(negedge clk);
      check_bit("reg_rvalid_o", 1'b0, reg_rvalid);
    end
    read_check(`GR_PAD_MUX_OFFSET);
    read_check(`GR_PAD_PULL_OFFSET);
    report_test("reset state", err0);

    // ----------------------------------------------------------
    // Register access
    // ----------------------------------------------------------
    err0 = errors;
    for (int i = 0; i < N_REG; i++) begin
      addr = pick_addr();
      r    = rand_data();
      if (r[0]) begin
        write_reg(addr, rand_data());
        @(negedge clk);
        idle_port();
        check_bit("reg_rvalid_o", 1'b0, reg_rvalid);
      end else begin
        read_check(addr);
      end
    end
    report_test("register access", err0);

    // ----------------------------------------------------------
    // Output routing
    // ----------------------------------------------------------
    err0 = errors;
    for (int i = 0; i < N_OUT; i++) begin
      prim_out = rand_vec();
      prim_oe  = rand_vec();
      alt_out  = rand_vec();
      alt_oe   = rand_vec();
      if (i % 2 == 0) begin
        write_reg(`GR_PAD_MUX_OFFSET, rand_data());
      end
      @(negedge clk);
      idle_port();
      check_pads();
    end
    report_test("output routing", err0);

    // ----------------------------------------------------------
    // Input routing with pad_i at 0 since reset
    // ----------------------------------------------------------
    err0 = errors;
    for (int i = 0; i < N_IN; i++) begin
      pad_in = rand_vec();
      if (i % 4 == 0) begin
        write_reg(`GR_PAD_MUX_OFFSET, rand_data());
      end
      sync_m = meta_m;
      meta_m = pad_in;
      @(negedge clk);
      idle_port();
      check_vec("prim_in_o", sync_m & ~mux_m, prim_in);
      check_vec("alt_in_o", sync_m & mux_m, alt_in);
    end
    report_test("input routing", err0);

    // ----------------------------------------------------------
    // Pull reporting
    // ----------------------------------------------------------
    err0 = errors;
    for (int i = 0; i < N_PULL; i++) begin
      prim_oe = rand_vec();
      alt_oe  = rand_vec();
      if (i % 2 == 0) begin
        write_reg(`GR_PAD_PULL_OFFSET, rand_data());
      end else begin
        write_reg(`GR_PAD_MUX_OFFSET, rand_data());
      end
      @(negedge clk);
      idle_port();
      check_pads();
    end
    report_test("pull reporting", err0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== bench/gr_pad_assert.sv ====
/*
  Register port and pad safety assertions for gr_pad_top.
  The read response rule holds only for strobes seen while rst_n_i
  is high; requests during synchronizer release are not covered.
*/
module gr_pad_assert import gr_pad_pkg::*; (
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     reg_valid_i,
  input logic     reg_write_i,
  input logic     rvalid_i,
  input pad_vec_t pad_oe_i,
  input pad_vec_t pad_pull_i
);

  logic rd_req;

  assign rd_req = reg_valid_i & ~reg_write_i;

  // One response per read, one cycle later
  rvalid_follows_read: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rvalid_i == $past(rd_req)
  ) else $error("reg_rvalid_o does not follow the read strobe by one cycle");

  no_pull_while_driving: assert property (
    @(posedge clk_i) (pad_oe_i & pad_pull_i) == '0
  ) else $error("pad_oe_o and pad_pull_o both high on a pad");

  no_drive_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> pad_oe_i == '0
  ) else $error("pad_oe_o not zero while rst_n_i is low");

endmodule

// ==== source/gr_pad_top.sv ====
/*
  Pad subsystem top level.
  rst_n_i is asynchronous and is synchronized inside before use.
  Pads are split into pad_i, pad_o and pad_oe_o; the tristate
  buffer lives outside this block.
*/
module gr_pad_top import gr_pad_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,

  // Register port
  input  logic      reg_valid_i,
  input  logic      reg_write_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_rvalid_o,

  // Function side
  input  pad_vec_t  prim_out_i,
  input  pad_vec_t  prim_oe_i,
  output pad_vec_t  prim_in_o,
  input  pad_vec_t  alt_out_i,
  input  pad_vec_t  alt_oe_i,
  output pad_vec_t  alt_in_o,

  // Pad side
  input  pad_vec_t  pad_i,
  output pad_vec_t  pad_o,
  output pad_vec_t  pad_oe_o,
  output pad_vec_t  pad_pull_o
);

  logic     rst_sync_n;
  pad_vec_t mux_sel;
  pad_vec_t pull_en;
  pad_vec_t mux_out;
  pad_vec_t mux_oe;
  pad_vec_t pad_in_sync;

  pad_control u_pad_control (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_rvalid_o(reg_rvalid_o),
    .rst_sync_n_o(rst_sync_n),
    .mux_sel_o   (mux_sel),
    .pull_en_o   (pull_en)
  );

  pad_mux u_pad_mux (
    .prim_out_i(prim_out_i),
    .prim_oe_i (prim_oe_i),
    .alt_out_i (alt_out_i),
    .alt_oe_i  (alt_oe_i),
    .mux_sel_i (mux_sel),
    .pad_in_i  (pad_in_sync),
    .prim_in_o (prim_in_o),
    .alt_in_o  (alt_in_o),
    .pad_out_o (mux_out),
    .pad_oe_o  (mux_oe)
  );

  pad_ring u_pad_ring (
    .clk_i       (clk_i),
    .rst_sync_n_i(rst_sync_n),
    .out_i       (mux_out),
    .oe_i        (mux_oe),
    .pull_en_i   (pull_en),
    .pad_i       (pad_i),
    .pad_o       (pad_o),
    .pad_oe_o    (pad_oe_o),
    .pad_pull_o  (pad_pull_o),
    .in_sync_o   (pad_in_sync)
  );

endmodule

// ==== source/pad_ring.sv ====
/*
  Pad ring model with split in, out and enable ports.
  Output enables are held low while the synchronized reset is low.
  Pull is reported only on pads that are not driving.
  Pad inputs take two cycles through the synchronizer.
*/
module pad_ring import gr_pad_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_sync_n_i,
  input  pad_vec_t out_i,
  input  pad_vec_t oe_i,
  input  pad_vec_t pull_en_i,
  input  pad_vec_t pad_i,
  output pad_vec_t pad_o,
  output pad_vec_t pad_oe_o,
  output pad_vec_t pad_pull_o,
  output pad_vec_t in_sync_o
);

  pad_vec_t oe_gated;
  pad_vec_t in_meta_q;
  pad_vec_t in_sync_q;

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------

  assign oe_gated   = rst_sync_n_i ? oe_i : '0;
  assign pad_o      = out_i;
  assign pad_oe_o   = oe_gated;
  assign pad_pull_o = pull_en_i & ~oe_gated;

  // ----------------------------------------------------------
  // Input synchronizer
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_sync_n_i) begin
    if (!rst_sync_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= pad_i;
      in_sync_q <= in_meta_q;
    end
  end

  assign in_sync_o = in_sync_q;

endmodule

// ==== source/pad_mux.sv ====
/*
  Per-pad function multiplexer, purely combinational.
  Select 0 routes the primary function, 1 the alternate.
  The function that is not selected sees 0 on its input.
*/
module pad_mux import gr_pad_pkg::*; (
  input  pad_vec_t prim_out_i,
  input  pad_vec_t prim_oe_i,
  input  pad_vec_t alt_out_i,
  input  pad_vec_t alt_oe_i,
  input  pad_vec_t mux_sel_i,
  input  pad_vec_t pad_in_i,
  output pad_vec_t prim_in_o,
  output pad_vec_t alt_in_o,
  output pad_vec_t pad_out_o,
  output pad_vec_t pad_oe_o
);

  always_comb begin
    prim_in_o = '0;
    alt_in_o  = '0;
    pad_out_o = '0;
    pad_oe_o  = '0;
    for (int i = 0; i < $bits(pad_vec_t); i++) begin
      if (mux_sel_i[i]) begin
        // Alternate function owns the pad
        pad_out_o[i] = alt_out_i[i];
        pad_oe_o[i]  = alt_oe_i[i];
        alt_in_o[i]  = pad_in_i[i];
      end else begin
        pad_out_o[i] = prim_out_i[i];
        pad_oe_o[i]  = prim_oe_i[i];
        prim_in_o[i] = pad_in_i[i];
      end
    end
  end

endmodule

// ==== source/pad_control.sv ====
/*
  Reset synchronizer and pad configuration registers.
  Strobe port with no back-pressure. A read answers on the next cycle
  with reg_rvalid_o high for one cycle. Unknown addresses read zero and
  ignore writes. Only the low GR_PAD_NUM data bits are kept.
  Select bit 0 is primary function, 1 is alternate.
*/
`include "gr_pad_params.svh"

module pad_control import gr_pad_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      reg_valid_i,
  input  logic      reg_write_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_rvalid_o,
  output logic      rst_sync_n_o,
  output pad_vec_t  mux_sel_o,
  output pad_vec_t  pull_en_o
);

  logic [1:0] rst_sync_q;
  logic       rst_sync_n;
  pad_vec_t   mux_sel_q;
  pad_vec_t   pull_en_q;
  reg_data_t  rdata_d;
  logic       wr_req;
  logic       rd_req;

  // ----------------------------------------------------------
  // Reset synchronizer
  // ----------------------------------------------------------

  // Asserts at once, releases after two rising edges
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n = rst_sync_q[1];

  // ----------------------------------------------------------
  // Register port
  // ----------------------------------------------------------

  assign wr_req = reg_valid_i & reg_write_i;
  assign rd_req = reg_valid_i & ~reg_write_i;

  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      mux_sel_q <= '0;
      pull_en_q <= '0;
    end else if (wr_req) begin
      case (reg_addr_i)
        `GR_PAD_MUX_OFFSET:  mux_sel_q <= reg_wdata_i[`GR_PAD_NUM-1:0];
        `GR_PAD_PULL_OFFSET: pull_en_q <= reg_wdata_i[`GR_PAD_NUM-1:0];
        default: ;
      endcase
    end
  end

  // Read mux with the upper bits left at zero
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      `GR_PAD_MUX_OFFSET:  rdata_d[`GR_PAD_NUM-1:0] = mux_sel_q;
      `GR_PAD_PULL_OFFSET: rdata_d[`GR_PAD_NUM-1:0] = pull_en_q;
      default:             rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= rd_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      reg_rdata_o <= rdata_d;
    end
  end

  assign rst_sync_n_o = rst_sync_n;
  assign mux_sel_o    = mux_sel_q;
  assign pull_en_o    = pull_en_q;

endmodule

// ==== source/gr_pad_pkg.sv ====
/*
  Shared types for the pad block.
  Widths come from gr_pad_params.svh. Pad vectors carry one bit
  per pad with bit i mapped to pad i.
*/
`include "gr_pad_params.svh"

package gr_pad_pkg;

  // ----------------------------------------------------------
  // Pad side
  // ----------------------------------------------------------

  // One bit per pad
  typedef logic [`GR_PAD_NUM-1:0] pad_vec_t;

  // ----------------------------------------------------------
  // Register port
  // ----------------------------------------------------------

  typedef logic [`GR_PAD_REG_AW-1:0] reg_addr_t;
  typedef logic [`GR_PAD_REG_DW-1:0] reg_data_t;

endpackage

// ==== source/gr_pad_params.svh ====
/*
  Pad ring build constants.
  GR_PAD_NUM must not exceed GR_PAD_REG_DW, since each register
  holds one bit per pad in its low bits.
  Register offsets must fit in GR_PAD_REG_AW bits.
*/
`ifndef GR_PAD_PARAMS_SVH
`define GR_PAD_PARAMS_SVH

// Pad count
`define GR_PAD_NUM 8

// Register port geometry
`define GR_PAD_REG_AW 4
`define GR_PAD_REG_DW 32

// Register map
`define GR_PAD_MUX_OFFSET  4'h0
`define GR_PAD_PULL_OFFSET 4'h4

`endif
